// ==== rtl/ttc_pkg.sv ====
// Shared types and constants for the single-channel timer; 16-bit data, 4-bit offsets, fixed map
`default_nettype none

package ttc_pkg;

  // --------------------------------------------------------------------------
  // Vector types
  // --------------------------------------------------------------------------
  typedef logic [15:0] data_t;       // Bus data, count and compare values
  typedef logic [3:0]  addr_t;       // Register offset
  typedef logic [6:0]  cntr_ctrl_t;  // Counter control register
  typedef logic [4:0]  clk_ctrl_t;   // Prescale enable plus divide exponent
  typedef logic [4:0]  intr_t;       // One bit per counter event

  // --------------------------------------------------------------------------
  // Register offsets
  // --------------------------------------------------------------------------
  localparam addr_t ADDR_CLK_CTRL  = 4'd0;
  localparam addr_t ADDR_CNTR_CTRL = 4'd1;
  localparam addr_t ADDR_INTERVAL  = 4'd2;
  localparam addr_t ADDR_MATCH1    = 4'd3;
  localparam addr_t ADDR_MATCH2    = 4'd4;
  localparam addr_t ADDR_MATCH3    = 4'd5;
  localparam addr_t ADDR_COUNT     = 4'd6;  // Read only
  localparam addr_t ADDR_INTR_STAT = 4'd7;  // Write one to clear
  localparam addr_t ADDR_INTR_EN   = 4'd8;

  // Clock control fields
  localparam int CLK_PS_EN   = 0;  // Prescale enable
  localparam int CLK_EXP_LSB = 1;  // Exponent occupies bits 4..1

  // Counter control bits
  localparam int CTRL_DIS      = 0;  // Disable, active high
  localparam int CTRL_INTERVAL = 1;  // Interval mode, else overflow
  localparam int CTRL_DECR     = 2;  // Count down
  localparam int CTRL_MATCH    = 3;  // Match compare on
  localparam int CTRL_RESTART  = 4;  // Self-clearing reload
  localparam int CTRL_WAVE_DIS = 5;  // Stored only
  localparam int CTRL_WAVE_POL = 6;  // Stored only

  // Interrupt vector bits
  localparam int INTR_INTERVAL = 0;
  localparam int INTR_MATCH1   = 1;
  localparam int INTR_MATCH2   = 2;
  localparam int INTR_MATCH3   = 3;
  localparam int INTR_OVERFLOW = 4;

  // Reset value of counter control, disabled and nothing else
  localparam cntr_ctrl_t CNTR_CTRL_RST = 7'b000_0001;

endpackage

`default_nettype wire

// ==== rtl/ttc_reg_ctrl.sv ====
// Bus decode for single-cycle strobes only; no wait states, undefined offsets read zero
`timescale 1ns/1ps
`default_nettype none

module ttc_reg_ctrl (
  input  logic                  pclk3,
  input  logic                  n_p_reset3,
  input  logic                  wr_stb,         // One-cycle write strobe
  input  logic                  rd_stb,         // One-cycle read strobe
  input  ttc_pkg::addr_t        addr,
  input  ttc_pkg::data_t        wdata,
  // Readback from the datapath
  input  ttc_pkg::clk_ctrl_t    clk_ctrl,
  input  ttc_pkg::cntr_ctrl_t   cntr_ctrl,
  input  ttc_pkg::data_t        interval,
  input  ttc_pkg::data_t        match1,
  input  ttc_pkg::data_t        match2,
  input  ttc_pkg::data_t        match3,
  input  ttc_pkg::data_t        count_val,
  input  ttc_pkg::intr_t        intr_stat,
  input  ttc_pkg::intr_t        intr_en,
  // Write select strobes
  output logic                  clk_ctrl_sel,
  output logic                  cntr_ctrl_sel,
  output logic                  interval_sel,
  output logic                  match1_sel,
  output logic                  match2_sel,
  output logic                  match3_sel,
  output logic                  intr_en_sel,
  output logic                  intr_clr_sel,
  // Read return
  output ttc_pkg::data_t        rd_data,
  output logic                  rd_valid
);

  ttc_pkg::data_t rd_mux;  // Zero-extended value at the current offset

  // --------------------------------------------------------------------------
  // Write decode
  // --------------------------------------------------------------------------
  // Combinational so the register takes wdata on the strobe edge
  always_comb
  begin
    clk_ctrl_sel  = 1'b0;
    cntr_ctrl_sel = 1'b0;
    interval_sel  = 1'b0;
    match1_sel    = 1'b0;
    match2_sel    = 1'b0;
    match3_sel    = 1'b0;
    intr_en_sel   = 1'b0;
    intr_clr_sel  = 1'b0;
    if (wr_stb)
    begin
      case (addr)
        ttc_pkg::ADDR_CLK_CTRL:  clk_ctrl_sel  = 1'b1;
        ttc_pkg::ADDR_CNTR_CTRL: cntr_ctrl_sel = 1'b1;
        ttc_pkg::ADDR_INTERVAL:  interval_sel  = 1'b1;
        ttc_pkg::ADDR_MATCH1:    match1_sel    = 1'b1;
        ttc_pkg::ADDR_MATCH2:    match2_sel    = 1'b1;
        ttc_pkg::ADDR_MATCH3:    match3_sel    = 1'b1;
        ttc_pkg::ADDR_INTR_STAT: intr_clr_sel  = 1'b1;  // Write one to clear
        ttc_pkg::ADDR_INTR_EN:   intr_en_sel   = 1'b1;
        default:                 ;                      // Count and holes ignore writes
      endcase
    end
  end

  // --------------------------------------------------------------------------
  // Read mux and return register
  // --------------------------------------------------------------------------
  always_comb
  begin
    case (addr)
      ttc_pkg::ADDR_CLK_CTRL:  rd_mux = ttc_pkg::data_t'(clk_ctrl);
      ttc_pkg::ADDR_CNTR_CTRL: rd_mux = ttc_pkg::data_t'(cntr_ctrl);
      ttc_pkg::ADDR_INTERVAL:  rd_mux = interval;
      ttc_pkg::ADDR_MATCH1:    rd_mux = match1;
      ttc_pkg::ADDR_MATCH2:    rd_mux = match2;
      ttc_pkg::ADDR_MATCH3:    rd_mux = match3;
      ttc_pkg::ADDR_COUNT:     rd_mux = count_val;
      ttc_pkg::ADDR_INTR_STAT: rd_mux = ttc_pkg::data_t'(intr_stat);
      ttc_pkg::ADDR_INTR_EN:   rd_mux = ttc_pkg::data_t'(intr_en);
      default:                 rd_mux = '0;  // Unmapped offset
    endcase
  end

  always_ff @(posedge pclk3 or negedge n_p_reset3)
  begin : p_rd_ret
    if (!n_p_reset3)
    begin
      rd_data  <= '0;
      rd_valid <= 1'b0;
    end
    else
    begin
      rd_valid <= rd_stb;      // Exactly one cycle after the strobe
      if (rd_stb)
        rd_data <= rd_mux;     // Held until the next read
    end
  end

endmodule

`default_nettype wire

// ==== rtl/ttc_prescaler.sv ====
// Power-of-two prescaler; period 2^(exponent+1) up to 65536 cycles, divider restarts on write
`timescale 1ns/1ps
`default_nettype none

module ttc_prescaler (
  input  logic                pclk3,
  input  logic                n_p_reset3,
  input  logic                clk_ctrl_sel,  // Clock control write
  input  ttc_pkg::data_t      wdata,
  output ttc_pkg::clk_ctrl_t  clk_ctrl,
  output logic                count_en       // Counter step enable
);

  ttc_pkg::data_t div_cnt;   // Free divide counter
  ttc_pkg::data_t div_mask;  // Terminal value 2^(n+1)-1
  logic [3:0]     div_exp;

  assign div_exp  = clk_ctrl[ttc_pkg::CLK_EXP_LSB +: 4];
  // 2 << 15 still fits before the trim back to 16 bits
  assign div_mask = ttc_pkg::data_t'((32'd2 << div_exp) - 32'd1);

  // Pulse on wrap, or every cycle with prescaling off
  assign count_en = ~clk_ctrl[ttc_pkg::CLK_PS_EN] | (div_cnt == div_mask);

  always_ff @(posedge pclk3 or negedge n_p_reset3)
  begin : p_div
    if (!n_p_reset3)
    begin
      clk_ctrl <= '0;
      div_cnt  <= '0;
    end
    else if (clk_ctrl_sel)
    begin
      clk_ctrl <= wdata[4:0];
      div_cnt  <= '0;                  // Restart on any write
    end
    else if (div_cnt == div_mask)
      div_cnt <= '0;                   // Wrap at the power of two
    else
      div_cnt <= div_cnt + 16'd1;
  end

endmodule

`default_nettype wire

// ==== rtl/ttc_counter.sv ====
// 16-bit up/down counter with interval and overflow modes; interval value assumed static while running
`timescale 1ns/1ps
`default_nettype none

module ttc_counter (
  input  logic                 pclk3,
  input  logic                 n_p_reset3,
  input  logic                 count_en,       // From the prescaler
  input  ttc_pkg::data_t       wdata,
  input  logic                 cntr_ctrl_sel,
  input  logic                 interval_sel,
  input  logic                 match1_sel,
  input  logic                 match2_sel,
  input  logic                 match3_sel,
  output ttc_pkg::cntr_ctrl_t  cntr_ctrl,
  output ttc_pkg::data_t       interval,
  output ttc_pkg::data_t       match1,
  output ttc_pkg::data_t       match2,
  output ttc_pkg::data_t       match3,
  output ttc_pkg::data_t       count_val,
  output ttc_pkg::intr_t       intr_event      // Raw events, one per bit
);

  logic           counting;      // Has stepped since last restart
  logic           restart_pend;  // Restart acted on at the last edge
  logic           ev_gate;       // Events allowed this cycle
  logic           cnt_zero;
  ttc_pkg::data_t wrap_top;      // Upper end of the count range
  ttc_pkg::data_t cnt_next;

  // --------------------------------------------------------------------------
  // Event outputs
  // --------------------------------------------------------------------------
  assign ev_gate  = counting & ~cntr_ctrl[ttc_pkg::CTRL_RESTART]
                  & ~cntr_ctrl[ttc_pkg::CTRL_DIS];
  assign cnt_zero = (count_val == '0);

  // Zero means interval or overflow depending on mode
  assign intr_event[ttc_pkg::INTR_INTERVAL] = ev_gate & cnt_zero
                                            & cntr_ctrl[ttc_pkg::CTRL_INTERVAL];
  assign intr_event[ttc_pkg::INTR_OVERFLOW] = ev_gate & cnt_zero
                                            & ~cntr_ctrl[ttc_pkg::CTRL_INTERVAL];
  assign intr_event[ttc_pkg::INTR_MATCH1]   = ev_gate & cntr_ctrl[ttc_pkg::CTRL_MATCH]
                                            & (count_val == match1);
  assign intr_event[ttc_pkg::INTR_MATCH2]   = ev_gate & cntr_ctrl[ttc_pkg::CTRL_MATCH]
                                            & (count_val == match2);
  assign intr_event[ttc_pkg::INTR_MATCH3]   = ev_gate & cntr_ctrl[ttc_pkg::CTRL_MATCH]
                                            & (count_val == match3);

  // --------------------------------------------------------------------------
  // Register writes
  // --------------------------------------------------------------------------
  // Bits 5 and 6 are only stored for readback
  always_ff @(posedge pclk3 or negedge n_p_reset3)
  begin : p_regs
    if (!n_p_reset3)
    begin
      cntr_ctrl <= ttc_pkg::CNTR_CTRL_RST;
      interval  <= '0;
      match1    <= '0;
      match2    <= '0;
      match3    <= '0;
    end
    else
    begin
      if (cntr_ctrl_sel)
        cntr_ctrl <= wdata[6:0];                   // Bus write wins
      else if (restart_pend)
        cntr_ctrl[ttc_pkg::CTRL_RESTART] <= 1'b0;  // Self clear after reload
      if (interval_sel)
        interval <= wdata;
      if (match1_sel)
        match1 <= wdata;
      if (match2_sel)
        match2 <= wdata;
      if (match3_sel)
        match3 <= wdata;
    end
  end

  // --------------------------------------------------------------------------
  // Next count
  // --------------------------------------------------------------------------
  assign wrap_top = cntr_ctrl[ttc_pkg::CTRL_INTERVAL] ? interval : 16'hFFFF;

  always_comb
  begin
    cnt_next = count_val;
    if (cntr_ctrl[ttc_pkg::CTRL_RESTART])
    begin
      // Reload, zero going up, top of range going down
      if (cntr_ctrl[ttc_pkg::CTRL_DECR])
        cnt_next = wrap_top;
      else
        cnt_next = '0;
    end
    else if (!cntr_ctrl[ttc_pkg::CTRL_DIS])
    begin
      if (cntr_ctrl[ttc_pkg::CTRL_DECR])
      begin
        if (cnt_zero)
          cnt_next = wrap_top;                     // Underflow wraps to top
        else
          cnt_next = count_val - 16'd1;
      end
      else
      begin
        if (count_val == wrap_top)
          cnt_next = '0;                           // Wrap back to zero
        else
          cnt_next = count_val + 16'd1;
      end
    end
  end

  // Count state only moves on enabled edges
  always_ff @(posedge pclk3 or negedge n_p_reset3)
  begin : p_cntr
    if (!n_p_reset3)
    begin
      count_val <= '0;
      counting  <= 1'b0;
    end
    else if (count_en)
    begin
      count_val <= cnt_next;
      if (cntr_ctrl[ttc_pkg::CTRL_RESTART])
        counting <= 1'b0;                          // Hold off events after reload
      else if (!cntr_ctrl[ttc_pkg::CTRL_DIS])
        counting <= 1'b1;
    end
  end

  // One-cycle flag, clears the restart bit on the following edge
  always_ff @(posedge pclk3 or negedge n_p_reset3)
  begin : p_restart
    if (!n_p_reset3)
      restart_pend <= 1'b0;
    else
      restart_pend <= count_en & cntr_ctrl[ttc_pkg::CTRL_RESTART];
  end

endmodule

`default_nettype wire

// ==== rtl/ttc_intr_status.sv ====
// Sticky interrupt status with write-one-to-clear; a same-cycle event beats the clear
`timescale 1ns/1ps
`default_nettype none

module ttc_intr_status (
  input  logic            pclk3,
  input  logic            n_p_reset3,
  input  ttc_pkg::intr_t  intr_event,    // Raw counter events
  input  logic            intr_en_sel,   // Enable mask write
  input  logic            intr_clr_sel,  // Status clear write
  input  ttc_pkg::data_t  wdata,
  output ttc_pkg::intr_t  intr_stat,
  output ttc_pkg::intr_t  intr_en,
  output logic            irq
);

  ttc_pkg::intr_t clr_mask;  // Bits to drop this cycle

  assign clr_mask = intr_clr_sel ? wdata[4:0] : '0;

  // Level output, no extra register stage
  assign irq = |(intr_stat & intr_en);

  // --------------------------------------------------------------------------
  // Status and enable registers
  // --------------------------------------------------------------------------
  always_ff @(posedge pclk3 or negedge n_p_reset3)
  begin : p_stat
    if (!n_p_reset3)
      intr_stat <= '0;
    else
      intr_stat <= (intr_stat & ~clr_mask) | intr_event;  // Set has priority
  end

  always_ff @(posedge pclk3 or negedge n_p_reset3)
  begin : p_en
    if (!n_p_reset3)
      intr_en <= '0;
    else if (intr_en_sel)
      intr_en <= wdata[4:0];
  end

endmodule

`default_nettype wire

// ==== rtl/ttc_top.sv ====
// Single-channel timer top level; strobe bus with no back-pressure, waveform output not built
`timescale 1ns/1ps
`default_nettype none

module ttc_top (
  input  logic            pclk3,
  input  logic            n_p_reset3,
  input  logic            wr_stb,
  input  logic            rd_stb,
  input  ttc_pkg::addr_t  addr,
  input  ttc_pkg::data_t  wdata,
  output ttc_pkg::data_t  rd_data,
  output logic            rd_valid,
  output logic            irq       // Level interrupt
);

  // Select strobes
  logic clk_ctrl_sel;
  logic cntr_ctrl_sel;
  logic interval_sel;
  logic match1_sel;
  logic match2_sel;
  logic match3_sel;
  logic intr_en_sel;
  logic intr_clr_sel;

  // Readback and datapath links
  ttc_pkg::clk_ctrl_t  clk_ctrl;
  ttc_pkg::cntr_ctrl_t cntr_ctrl;
  ttc_pkg::data_t      interval;
  ttc_pkg::data_t      match1;
  ttc_pkg::data_t      match2;
  ttc_pkg::data_t      match3;
  ttc_pkg::data_t      count_val;
  ttc_pkg::intr_t      intr_stat;
  ttc_pkg::intr_t      intr_en;
  ttc_pkg::intr_t      intr_event;
  logic                count_en;

  // --------------------------------------------------------------------------
  // Bus side
  // --------------------------------------------------------------------------
  ttc_reg_ctrl u_reg_ctrl (
    .pclk3         (pclk3),
    .n_p_reset3    (n_p_reset3),
    .wr_stb        (wr_stb),
    .rd_stb        (rd_stb),
    .addr          (addr),
    .wdata         (wdata),
    .clk_ctrl      (clk_ctrl),
    .cntr_ctrl     (cntr_ctrl),
    .interval      (interval),
    .match1        (match1),
    .match2        (match2),
    .match3        (match3),
    .count_val     (count_val),
    .intr_stat     (intr_stat),
    .intr_en       (intr_en),
    .clk_ctrl_sel  (clk_ctrl_sel),
    .cntr_ctrl_sel (cntr_ctrl_sel),
    .interval_sel  (interval_sel),
    .match1_sel    (match1_sel),
    .match2_sel    (match2_sel),
    .match3_sel    (match3_sel),
    .intr_en_sel   (intr_en_sel),
    .intr_clr_sel  (intr_clr_sel),
    .rd_data       (rd_data),
    .rd_valid      (rd_valid)
  );

  // --------------------------------------------------------------------------
  // Datapath
  // --------------------------------------------------------------------------
  ttc_prescaler u_prescaler (
    .pclk3        (pclk3),
    .n_p_reset3   (n_p_reset3),
    .clk_ctrl_sel (clk_ctrl_sel),
    .wdata        (wdata),
    .clk_ctrl     (clk_ctrl),
    .count_en     (count_en)
  );

  ttc_counter u_counter (
    .pclk3         (pclk3),
    .n_p_reset3    (n_p_reset3),
    .count_en      (count_en),
    .wdata         (wdata),
    .cntr_ctrl_sel (cntr_ctrl_sel),
    .interval_sel  (interval_sel),
    .match1_sel    (match1_sel),
    .match2_sel    (match2_sel),
    .match3_sel    (match3_sel),
    .cntr_ctrl     (cntr_ctrl),
    .interval      (interval),
    .match1        (match1),
    .match2        (match2),
    .match3        (match3),
    .count_val     (count_val),
    .intr_event    (intr_event)
  );

  ttc_intr_status u_intr_status (
    .pclk3        (pclk3),
    .n_p_reset3   (n_p_reset3),
    .intr_event   (intr_event),
    .intr_en_sel  (intr_en_sel),
    .intr_clr_sel (intr_clr_sel),
    .wdata        (wdata),
    .intr_stat    (intr_stat),
    .intr_en      (intr_en),
    .irq          (irq)
  );

endmodule

`default_nettype wire

// ==== sim/ttc_asserts.sv ====
// Concurrent checks bound into ttc_top; relies on its internal net names, idle during reset
`timescale 1ns/1ps
`default_nettype none

module ttc_asserts (
  input  logic                 pclk3,
  input  logic                 n_p_reset3,
  input  logic                 rd_stb,
  input  logic                 rd_valid,
  input  logic                 irq,
  input  logic                 count_en,
  input  logic                 cntr_ctrl_sel,
  input  ttc_pkg::cntr_ctrl_t  cntr_ctrl,
  input  logic                 intr_en_sel,
  input  ttc_pkg::intr_t       intr_event,
  input  ttc_pkg::intr_t       intr_en
);

  // --------------------------------------------------------------------------
  // Bus return timing
  // --------------------------------------------------------------------------
  a_rd_valid: assert property (@(posedge pclk3) disable iff (!n_p_reset3)
    rd_valid == $past(rd_stb))
    else $error("rd_valid does not follow rd_stb by one cycle");

  // Restart bit drops one cycle after the reload, unless rewritten
  a_restart_clr: assert property (@(posedge pclk3) disable iff (!n_p_reset3)
    ($past(count_en && cntr_ctrl[ttc_pkg::CTRL_RESTART]) && !cntr_ctrl_sel)
    |=> !cntr_ctrl[ttc_pkg::CTRL_RESTART])
    else $error("Restart bit still set after the counter reloaded");

  // New enabled status bit comes from an enabled event or a mask write
  a_irq_src: assert property (@(posedge pclk3) disable iff (!n_p_reset3)
    $rose(irq) |-> $past(|(intr_event & intr_en)) || $past(intr_en_sel))
    else $error("irq rose without an enabled event or a mask write");

endmodule

bind ttc_top ttc_asserts u_asserts (
  .pclk3         (pclk3),
  .n_p_reset3    (n_p_reset3),
  .rd_stb        (rd_stb),
  .rd_valid      (rd_valid),
  .irq           (irq),
  .count_en      (count_en),
  .cntr_ctrl_sel (cntr_ctrl_sel),
  .cntr_ctrl     (cntr_ctrl),
  .intr_en_sel   (intr_en_sel),
  .intr_event    (intr_event),
  .intr_en       (intr_en)
);

`default_nettype wire

// ==== sim/tb_ttc.sv ====
// Self-checking testbench for ttc_top; needs a simulator with timing support, stops at the first mismatch
`timescale 1ns/1ps
`default_nettype none

module tb_ttc;

  localparam int RD_TIMEOUT      = 8;    // Cycles allowed for rd_valid
  localparam int RESTART_TIMEOUT = 200;  // Reads allowed for the restart bit to drop

  logic           pclk3;
  logic           n_p_reset3;
  logic           wr_stb;
  logic           rd_stb;
  ttc_pkg::addr_t addr;
  ttc_pkg::data_t wdata;
  ttc_pkg::data_t rd_data;
  logic           rd_valid;
  logic           irq;

  // Reference model state, updated on every rising edge
  ttc_pkg::clk_ctrl_t  m_clk;
  ttc_pkg::data_t      m_div;       // Prescaler phase
  ttc_pkg::cntr_ctrl_t m_ctrl;
  ttc_pkg::data_t      m_interval;
  ttc_pkg::data_t      m_match1;
  ttc_pkg::data_t      m_match2;
  ttc_pkg::data_t      m_match3;
  ttc_pkg::data_t      m_count;
  logic                m_counting;  // Stepped since the last reload
  logic                m_pend;      // Reload happened at the last edge
  ttc_pkg::intr_t      m_stat;
  ttc_pkg::intr_t      m_en;
  logic                irq_check_on;

  ttc_top u_dut (
    .pclk3      (pclk3),
    .n_p_reset3 (n_p_reset3),
    .wr_stb     (wr_stb),
    .rd_stb     (rd_stb),
    .addr       (addr),
    .wdata      (wdata),
    .rd_data    (rd_data),
    .rd_valid   (rd_valid),
    .irq        (irq)
  );

  initial
  begin : p_clk
    pclk3 = 1'b0;
    forever #5 pclk3 = ~pclk3;  // 10 ns period
  end

  // --------------------------------------------------------------------------
  // Error handling and compare tasks
  // --------------------------------------------------------------------------
  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Simulation finished: FAIL");
    $fatal(1, "Stopping at the first error");
  endtask

  task automatic check_data(input string name, input ttc_pkg::data_t got,
                            input ttc_pkg::data_t exp);
    if (got !== exp)
      stop_on_error($sformatf("CHECK FAILED %s: got %h expected %h", name, got, exp));
  endtask

  task automatic check_intr(input string name, input ttc_pkg::intr_t got,
                            input ttc_pkg::intr_t exp);
    if (got !== exp)
      stop_on_error($sformatf("CHECK FAILED %s: got %h expected %h", name, got, exp));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
      stop_on_error($sformatf("CHECK FAILED %s: got %h expected %h", name, got, exp));
  endtask

  // --------------------------------------------------------------------------
  // Reference model
  // --------------------------------------------------------------------------
  task automatic model_reset();
    m_clk      = '0;
    m_div      = '0;
    m_ctrl     = 7'h01;  // Counter disabled, nothing else
    m_interval = '0;
    m_match1   = '0;
    m_match2   = '0;
    m_match3   = '0;
    m_count    = '0;
    m_counting = 1'b0;
    m_pend     = 1'b0;
    m_stat     = '0;
    m_en       = '0;
  endtask

  // Expected readback for an offset, zero-extended
  function automatic ttc_pkg::data_t model_read(input ttc_pkg::addr_t a);
    case (a)
      ttc_pkg::ADDR_CLK_CTRL:  return {11'h0, m_clk};
      ttc_pkg::ADDR_CNTR_CTRL: return {9'h0, m_ctrl};
      ttc_pkg::ADDR_INTERVAL:  return m_interval;
      ttc_pkg::ADDR_MATCH1:    return m_match1;
      ttc_pkg::ADDR_MATCH2:    return m_match2;
      ttc_pkg::ADDR_MATCH3:    return m_match3;
      ttc_pkg::ADDR_COUNT:     return m_count;
      ttc_pkg::ADDR_INTR_STAT: return {11'h0, m_stat};
      ttc_pkg::ADDR_INTR_EN:   return {11'h0, m_en};
      default:                 return 16'h0000;  // Holes in the map
    endcase
  endfunction

  always @(posedge pclk3)
  begin : p_model
    ttc_pkg::data_t top_v;   // Upper end of range
    ttc_pkg::data_t mask_v;  // Prescaler terminal value
    ttc_pkg::intr_t ev_v;
    ttc_pkg::intr_t clr_v;
    logic           en_v;
    logic           gate_v;
    logic           pend_v;
    if (!n_p_reset3)
      model_reset();
    else
    begin
      // Everything below the line uses state from before this edge
      mask_v = 16'hFFFF >> (4'd15 - m_clk[4:1]);  // 2^(n+1)-1
      en_v   = !m_clk[0] || (m_div == mask_v);
      top_v  = m_ctrl[ttc_pkg::CTRL_INTERVAL] ? m_interval : 16'hFFFF;
      gate_v = m_counting && !m_ctrl[ttc_pkg::CTRL_RESTART] && !m_ctrl[ttc_pkg::CTRL_DIS];
      pend_v = m_pend;

      // Events seen this cycle
      ev_v = '0;
      if (gate_v && m_count == 16'h0000)
      begin
        if (m_ctrl[ttc_pkg::CTRL_INTERVAL])
          ev_v[ttc_pkg::INTR_INTERVAL] = 1'b1;
        else
          ev_v[ttc_pkg::INTR_OVERFLOW] = 1'b1;
      end
      if (gate_v && m_ctrl[ttc_pkg::CTRL_MATCH])
      begin
        ev_v[ttc_pkg::INTR_MATCH1] = (m_count == m_match1);
        ev_v[ttc_pkg::INTR_MATCH2] = (m_count == m_match2);
        ev_v[ttc_pkg::INTR_MATCH3] = (m_count == m_match3);
      end
      clr_v  = (wr_stb && addr == ttc_pkg::ADDR_INTR_STAT) ? wdata[4:0] : 5'h00;
      m_stat = (m_stat & ~clr_v) | ev_v;  // Event beats clear
      if (wr_stb && addr == ttc_pkg::ADDR_INTR_EN)
        m_en = wdata[4:0];

      // Counter step
      m_pend = en_v && m_ctrl[ttc_pkg::CTRL_RESTART];
      if (en_v)
      begin
        if (m_ctrl[ttc_pkg::CTRL_RESTART])
        begin
          m_count    = m_ctrl[ttc_pkg::CTRL_DECR] ? top_v : 16'h0000;
          m_counting = 1'b0;
        end
        else if (!m_ctrl[ttc_pkg::CTRL_DIS])
        begin
          if (m_ctrl[ttc_pkg::CTRL_DECR])
            m_count = (m_count == 16'h0000) ? top_v : m_count - 16'd1;
          else
            m_count = (m_count == top_v) ? 16'h0000 : m_count + 16'd1;
          m_counting = 1'b1;
        end
      end

      // Register writes last, so the step above saw old values
      if (wr_stb && addr == ttc_pkg::ADDR_CNTR_CTRL)
        m_ctrl = wdata[6:0];
      else if (pend_v)
        m_ctrl[ttc_pkg::CTRL_RESTART] = 1'b0;
      if (wr_stb && addr == ttc_pkg::ADDR_INTERVAL)
        m_interval = wdata;
      if (wr_stb && addr == ttc_pkg::ADDR_MATCH1)
        m_match1 = wdata;
      if (wr_stb && addr == ttc_pkg::ADDR_MATCH2)
        m_match2 = wdata;
      if (wr_stb && addr == ttc_pkg::ADDR_MATCH3)
        m_match3 = wdata;
      if (wr_stb && addr == ttc_pkg::ADDR_CLK_CTRL)
      begin
        m_clk = wdata[4:0];
        m_div = '0;                    // Divider restarts
      end
      else if (m_div == mask_v)
        m_div = '0;
      else
        m_div = m_div + 16'd1;
    end
  end

  // irq compared on every falling edge, both sides settled by then
  always @(negedge pclk3)
  begin : p_irq_mon
    if (irq_check_on)
      check_bit("irq", irq, |(m_stat & m_en));
  end

  // --------------------------------------------------------------------------
  // Bus tasks, entered and left just after a falling edge
  // --------------------------------------------------------------------------
  function automatic int unsigned rand_range(input int unsigned lo, input int unsigned hi);
    return lo + ($urandom % (hi - lo + 1));
  endfunction

  function automatic ttc_pkg::data_t ctrl_word(input logic intv_mode, input logic decr,
                                               input logic match, input logic restart);
    ttc_pkg::data_t w;
    w = '0;                            // Enabled, waveform bits clear
    w[ttc_pkg::CTRL_INTERVAL] = intv_mode;
    w[ttc_pkg::CTRL_DECR]     = decr;
    w[ttc_pkg::CTRL_MATCH]    = match;
    w[ttc_pkg::CTRL_RESTART]  = restart;
    return w;
  endfunction

  task automatic idle(input int cycles);
    repeat (cycles) @(negedge pclk3);
  endtask

  task automatic write_reg(input ttc_pkg::addr_t a, input ttc_pkg::data_t d);
    wr_stb = 1'b1;
    addr   = a;
    wdata  = d;
    @(negedge pclk3);
    wr_stb = 1'b0;
  endtask

  task automatic read_reg(input ttc_pkg::addr_t a, output ttc_pkg::data_t val);
    ttc_pkg::data_t exp;
    int             waited;
    exp    = model_read(a);            // Value at the strobe edge
    rd_stb = 1'b1;
    addr   = a;
    waited = 0;
    do
    begin
      @(negedge pclk3);
      rd_stb = 1'b0;
      waited = waited + 1;
    end
    while (rd_valid !== 1'b1 && waited < RD_TIMEOUT);
    if (rd_valid !== 1'b1)
      stop_on_error("No rd_valid arrived within the read timeout");
    check_bit("rd_valid one cycle after rd_stb", waited == 1, 1'b1);
    if (a == ttc_pkg::ADDR_INTR_STAT || a == ttc_pkg::ADDR_INTR_EN)
    begin
      check_intr($sformatf("rd_data intr @%h", a), rd_data[4:0], exp[4:0]);
      check_data("rd_data intr upper bits", rd_data >> 5, 16'h0000);
    end
    else
      check_data($sformatf("rd_data @%h", a), rd_data, exp);
    val = rd_data;
  endtask

  // Poll control until the reload has cleared the restart bit
  task automatic wait_restart_clear();
    ttc_pkg::data_t rv;
    int             tries;
    tries = 0;
    read_reg(ttc_pkg::ADDR_CNTR_CTRL, rv);
    while (rv[ttc_pkg::CTRL_RESTART] && tries < RESTART_TIMEOUT)
    begin
      read_reg(ttc_pkg::ADDR_CNTR_CTRL, rv);
      tries = tries + 1;
    end
    if (rv[ttc_pkg::CTRL_RESTART])
      stop_on_error("Restart bit in counter control never cleared");
  endtask

  // --------------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------------
  initial
  begin : p_main
    ttc_pkg::data_t rv;
    int unsigned    intv;
    int unsigned    ps_exp;
    int unsigned    op;
    int             i;
    int             dir;
    void'($urandom(97781));            // Fixed seed, once
    n_p_reset3   = 1'b0;
    wr_stb       = 1'b0;
    rd_stb       = 1'b0;
    addr         = '0;
    wdata        = '0;
    irq_check_on = 1'b0;
    repeat (16) @(posedge pclk3);
    @(negedge pclk3);
    n_p_reset3 = 1'b1;
    check_bit("irq after reset", irq, 1'b0);
    check_bit("rd_valid after reset", rd_valid, 1'b0);
    irq_check_on = 1'b1;

    // Reset values and undefined offsets
    for (i = 0; i < 16; i = i + 1)
      read_reg(ttc_pkg::addr_t'(i), rv);

    // Random register traffic over the whole map
    repeat (300)
    begin
      if ($urandom % 2)
        write_reg(ttc_pkg::addr_t'($urandom % 16), ttc_pkg::data_t'($urandom));
      else
        read_reg(ttc_pkg::addr_t'($urandom % 16), rv);
    end

    // Overflow mode, full wrap each way
    write_reg(ttc_pkg::ADDR_CLK_CTRL, 16'h0000);
    for (dir = 0; dir < 2; dir = dir + 1)
    begin
      write_reg(ttc_pkg::ADDR_CNTR_CTRL, ctrl_word(1'b0, dir[0], 1'b0, 1'b1));
      write_reg(ttc_pkg::ADDR_INTR_STAT, 16'h001F);
      repeat (6)
      begin
        idle(int'(rand_range(1, 400)));
        read_reg(ttc_pkg::ADDR_COUNT, rv);
      end
      idle(66000);                     // Past FFFF/0000
      read_reg(ttc_pkg::ADDR_COUNT, rv);
      read_reg(ttc_pkg::ADDR_INTR_STAT, rv);
      check_bit("intr_stat overflow", rv[ttc_pkg::INTR_OVERFLOW], 1'b1);
    end

    // Interval mode with random interval values
    for (dir = 0; dir < 2; dir = dir + 1)
    begin
      intv = rand_range(20, 300);
      write_reg(ttc_pkg::ADDR_INTERVAL, ttc_pkg::data_t'(intv));
      write_reg(ttc_pkg::ADDR_CNTR_CTRL, ctrl_word(1'b1, dir[0], 1'b0, 1'b1));
      write_reg(ttc_pkg::ADDR_INTR_STAT, 16'h001F);
      repeat (8)
      begin
        idle(int'(rand_range(1, 60)));
        read_reg(ttc_pkg::ADDR_COUNT, rv);
      end
      idle(int'(intv) * 2 + 10);
      read_reg(ttc_pkg::ADDR_COUNT, rv);  // Past the wrap at the interval value
      read_reg(ttc_pkg::ADDR_INTR_STAT, rv);
      check_bit("intr_stat interval", rv[ttc_pkg::INTR_INTERVAL], 1'b1);
    end

    // Match mode on, then off
    intv = rand_range(40, 200);
    write_reg(ttc_pkg::ADDR_INTERVAL, ttc_pkg::data_t'(intv));
    write_reg(ttc_pkg::ADDR_MATCH1, ttc_pkg::data_t'(rand_range(1, intv - 1)));
    write_reg(ttc_pkg::ADDR_MATCH2, ttc_pkg::data_t'(rand_range(1, intv - 1)));
    write_reg(ttc_pkg::ADDR_MATCH3, ttc_pkg::data_t'(rand_range(1, intv - 1)));
    for (i = 0; i < 2; i = i + 1)
    begin
      write_reg(ttc_pkg::ADDR_CNTR_CTRL, ctrl_word(1'b1, 1'b0, (i == 0), 1'b1));
      write_reg(ttc_pkg::ADDR_INTR_STAT, 16'h001F);
      idle(int'(intv) * 2 + 10);
      read_reg(ttc_pkg::ADDR_INTR_STAT, rv);
      check_intr("intr_stat match bits", rv[4:0] & 5'b01110, (i == 0) ? 5'b01110 : 5'b00000);
    end

    // Prescaled counting and restart reload
    write_reg(ttc_pkg::ADDR_INTERVAL, 16'd500);
    repeat (4)
    begin
      ps_exp = rand_range(0, 4);
      write_reg(ttc_pkg::ADDR_CLK_CTRL, ttc_pkg::data_t'((ps_exp << 1) | 1));
      write_reg(ttc_pkg::ADDR_CNTR_CTRL,
                ctrl_word($urandom % 2 == 1, $urandom % 2 == 1, 1'b0, 1'b1));
      wait_restart_clear();
      read_reg(ttc_pkg::ADDR_COUNT, rv);
      repeat (5)
      begin
        idle(int'(rand_range(1, 120)));
        read_reg(ttc_pkg::ADDR_COUNT, rv);
      end
    end

    // Enable masks and clears against irq
    write_reg(ttc_pkg::ADDR_CLK_CTRL, 16'h0000);
    write_reg(ttc_pkg::ADDR_INTERVAL, 16'd30);
    write_reg(ttc_pkg::ADDR_MATCH1, 16'd5);
    write_reg(ttc_pkg::ADDR_MATCH2, 16'd12);
    write_reg(ttc_pkg::ADDR_MATCH3, 16'd21);
    write_reg(ttc_pkg::ADDR_CNTR_CTRL, ctrl_word(1'b1, 1'b0, 1'b1, 1'b1));
    repeat (150)
    begin
      op = $urandom % 4;
      case (op)
        0:       write_reg(ttc_pkg::ADDR_INTR_EN, ttc_pkg::data_t'($urandom % 32));
        1:       write_reg(ttc_pkg::ADDR_INTR_STAT, ttc_pkg::data_t'($urandom % 32));
        2:       read_reg(ttc_pkg::ADDR_INTR_STAT, rv);
        default: idle(int'(rand_range(1, 20)));
      endcase
    end

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
rtl/ttc_pkg.sv
rtl/ttc_reg_ctrl.sv
rtl/ttc_prescaler.sv
rtl/ttc_counter.sv
rtl/ttc_intr_status.sv
rtl/ttc_top.sv
sim/ttc_asserts.sv
sim/tb_ttc.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_ttc
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Simulation finished: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
